/* Bender.yml */
package:
  name: lsu_slice

sources:
  - hdl/lsu_pkg.sv
  - hdl/agu_stage.sv
  - hdl/mem_stage.sv
  - hdl/data_ram.sv
  - hdl/wb_regfile.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - bench/lsu_tb.sv

/* bench/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

    localparam int aw  = lsu_pkg::ram_addr_width_default;
    localparam int lat = lsu_pkg::ram_latency_default;
    // items issued by the five tests
    localparam int n_items  = 3 + 2 + 24 + 21 + 76;
    localparam int limit_ns = (n_items * (4 + lat) + 300) * 20;

    logic              clk;
    logic              reset;
    logic              issue_valid;
    lsu_pkg::mem_op_t  issue_op;
    lsu_pkg::word_t    issue_src1;
    lsu_pkg::word_t    issue_src2;
    lsu_pkg::word_t    issue_imm;
    lsu_pkg::reg_idx_t issue_wreg;
    logic              issue_wen;
    lsu_pkg::word_t    issue_pc;
    logic              issue_ready;
    logic              retire_valid;
    lsu_pkg::mem_op_t  retire_op;
    lsu_pkg::reg_idx_t retire_wreg;
    logic              retire_wen;
    lsu_pkg::word_t    retire_data;
    lsu_pkg::word_t    retire_pc;
    lsu_pkg::reg_idx_t rf_raddr;
    lsu_pkg::word_t    rf_rdata;

    // reference model and expected retire order
    lsu_pkg::word_t    ref_mem [0:(1<<aw)-1];
    lsu_pkg::word_t    ref_regs [0:31];
    lsu_pkg::word_t    exp_data [$];
    lsu_pkg::word_t    exp_pc [$];
    lsu_pkg::reg_idx_t exp_wreg [$];
    logic              exp_wen [$];
    lsu_pkg::mem_op_t  exp_op [$];
    lsu_pkg::word_t    pc_next;
    int                seed;
    int                issued;
    int                retired;

    lsu_top #(
        .ram_addr_width (aw),
        .ram_latency    (lat)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input lsu_pkg::word_t got,
                              input lsu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input lsu_pkg::reg_idx_t got,
                             input lsu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_op(input string name, input lsu_pkg::mem_op_t got,
                            input lsu_pkg::mem_op_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    initial begin
        #(limit_ns);
        abort_run("watchdog expired, the pipeline stopped retiring items");
    end

    // retire port checked in issue order
    always @(posedge clk) begin
        if (!reset && retire_valid) begin
            if (exp_data.size() == 0) begin
                abort_run("an item retired that was never issued");
            end else begin
                check_word("retire_data", retire_data, exp_data.pop_front());
                check_idx("retire_wreg", retire_wreg, exp_wreg.pop_front());
                check_bit("retire_wen", retire_wen, exp_wen.pop_front());
                check_word("retire_pc", retire_pc, exp_pc.pop_front());
                check_op("retire_op", retire_op, exp_op.pop_front());
                retired++;
            end
        end
    end

    // expected result by the lane rules with the memory model updated in issue order
    function automatic lsu_pkg::word_t predict(input lsu_pkg::mem_op_t op,
                                               input lsu_pkg::word_t src1,
                                               input lsu_pkg::word_t src2,
                                               input lsu_pkg::word_t imm);
        lsu_pkg::word_t addr;
        lsu_pkg::word_t w;
        logic [7:0]     b;
        logic [15:0]    h;
        addr = src1 + imm;
        w    = ref_mem[addr[aw+1:2]];
        b    = w[8 * addr[1:0] +: 8];
        h    = w[16 * addr[1] +: 16];
        case (op)
            lsu_pkg::op_alu: return src1 + src2;
            lsu_pkg::op_lb:  return {{24{b[7]}}, b};
            lsu_pkg::op_lbu: return {24'h0, b};
            lsu_pkg::op_lh:  return {{16{h[15]}}, h};
            lsu_pkg::op_lhu: return {16'h0, h};
            lsu_pkg::op_lw:  return w;
            lsu_pkg::op_sb:  ref_mem[addr[aw+1:2]][8 * addr[1:0] +: 8] = src2[7:0];
            lsu_pkg::op_sh:  ref_mem[addr[aw+1:2]][16 * addr[1] +: 16] = src2[15:0];
            default:         ref_mem[addr[aw+1:2]] = src2;
        endcase
        // stores retire their address
        return addr;
    endfunction

    task automatic send_op(input lsu_pkg::mem_op_t op, input lsu_pkg::word_t src1,
                           input lsu_pkg::word_t src2, input lsu_pkg::word_t imm,
                           input lsu_pkg::reg_idx_t wreg, input logic wen);
        lsu_pkg::word_t exp;
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_src1  <= src1;
        issue_src2  <= src2;
        issue_imm   <= imm;
        issue_wreg  <= wreg;
        issue_wen   <= wen;
        issue_pc    <= pc_next;
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        exp = predict(op, src1, src2, imm);
        if (wen && wreg != 5'd0) begin
            ref_regs[wreg] = exp;
        end
        exp_data.push_back(exp);
        exp_wreg.push_back(wreg);
        exp_wen.push_back(wen);
        exp_pc.push_back(pc_next);
        exp_op.push_back(op);
        pc_next = pc_next + 32'd4;
        issued++;
    endtask

    task automatic drain_pipe();
        int waited;
        issue_valid <= 1'b0;
        waited = 0;
        while (exp_data.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 4 * (4 + lat)) begin
                abort_run("issued items stayed outstanding without retiring");
            end
        end
    endtask

    task automatic check_reg(input lsu_pkg::reg_idx_t idx);
        rf_raddr <= idx;
        @(posedge clk);
        check_word($sformatf("rf_rdata[%0d]", idx), rf_rdata, ref_regs[idx]);
    endtask

    task automatic test_alu_add();
        send_op(lsu_pkg::op_alu, 32'h1234_5678, 32'h0fed_cba9, 32'hdead_beef, 5'd5, 1'b1);
        send_op(lsu_pkg::op_alu, 32'hffff_ffff, 32'h0000_0002, 32'h0, 5'd7, 1'b1);
        // retires, yet register 0 keeps zero
        send_op(lsu_pkg::op_alu, 32'h0bad_f00d, 32'h1111_1111, 32'h0, 5'd0, 1'b1);
        drain_pipe();
        check_reg(5'd5);
        check_reg(5'd7);
        check_reg(5'd0);
    endtask

    task automatic test_word_store_load();
        lsu_pkg::word_t value;
        value = $random(seed);
        send_op(lsu_pkg::op_sw, 32'h0000_0180, value, 32'h4, 5'd3, 1'b0);
        send_op(lsu_pkg::op_lw, 32'h0000_0184, 32'h0, 32'h0, 5'd9, 1'b1);
        drain_pipe();
        check_reg(5'd9);
    endtask

    task automatic test_lane_stores();
        lsu_pkg::word_t base;
        for (int lane = 0; lane < 4; lane++) begin
            base = 32'h0000_0200 + 4 * lane;
            send_op(lsu_pkg::op_sw, base, 32'h0, 32'h0, 5'd0, 1'b0);
            send_op(lsu_pkg::op_sb, base, $random(seed), lane, 5'd0, 1'b0);
            send_op(lsu_pkg::op_lw, base, 32'h0, 32'h0, 5'(10 + lane), 1'b1);
            // half lane follows address bit 1
            base = base + 32'h20;
            send_op(lsu_pkg::op_sw, base, 32'h0, 32'h0, 5'd0, 1'b0);
            send_op(lsu_pkg::op_sh, base, $random(seed), lane, 5'd0, 1'b0);
            send_op(lsu_pkg::op_lw, base, 32'h0, 32'h0, 5'(14 + lane), 1'b1);
        end
        drain_pipe();
    endtask

    task automatic test_load_extend();
        lsu_pkg::mem_op_t ops [5];
        ops = '{lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_lh, lsu_pkg::op_lhu,
                lsu_pkg::op_lw};
        // both signs in bytes and halves
        send_op(lsu_pkg::op_sw, 32'h0000_0300, 32'h80ff_7f01, 32'h0, 5'd0, 1'b0);
        foreach (ops[i]) begin
            for (int lane = 0; lane < 4; lane++) begin
                send_op(ops[i], 32'h0000_02f8, 32'h0, 8 + lane, 5'(20 + lane), 1'b1);
            end
        end
        drain_pipe();
    endtask

    task automatic test_random_stream();
        lsu_pkg::word_t   addr;
        lsu_pkg::word_t   offset;
        lsu_pkg::word_t   rnd;
        lsu_pkg::mem_op_t op;
        int               pick;
        // fill the region so every load reads written data
        for (int i = 0; i < 16; i++) begin
            addr = 32'h0000_0100 + 4 * i;
            send_op(lsu_pkg::op_sw, addr, (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]},
                    32'h0, 5'd0, 1'b0);
        end
        for (int i = 0; i < 60; i++) begin
            pick   = $unsigned($random(seed)) % 9;
            op     = lsu_pkg::mem_op_t'(pick[3:0]);
            offset = $random(seed) & 32'h0000_00ff;
            rnd    = $random(seed);
            addr   = 32'h0000_0100 + (rnd & 32'h0000_003f);
            rnd    = $random(seed);
            send_op(op, addr + offset, $random(seed), -offset, rnd[4:0], rnd[5]);
        end
        drain_pipe();
        for (int r = 0; r < 32; r++) begin
            check_reg(5'(r));
        end
    endtask

    initial begin
        seed        = 30;
        pc_next     = 32'h0000_1000;
        issued      = 0;
        retired     = 0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = lsu_pkg::op_alu;
        issue_src1  = '0;
        issue_src2  = '0;
        issue_imm   = '0;
        issue_wreg  = '0;
        issue_wen   = 1'b0;
        issue_pc    = '0;
        rf_raddr    = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_alu_add();
        test_word_store_load();
        test_lane_stores();
        test_load_extend();
        test_random_stream();
        // late duplicates would show up here
        repeat (10) @(posedge clk);
        if (exp_data.size() == 0 && retired == issued) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d items issued but %0d retired", issued, retired));
        end
    end

endmodule

/* hdl/agu_stage.sv */
`timescale 1ns/1ps

module agu_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  lsu_pkg::mem_op_t  issue_op,
    input  lsu_pkg::word_t    issue_src1,
    input  lsu_pkg::word_t    issue_src2,
    input  lsu_pkg::word_t    issue_imm,
    input  lsu_pkg::reg_idx_t issue_wreg,
    input  logic              issue_wen,
    input  lsu_pkg::word_t    issue_pc,
    input  logic              mem_ready,
    output logic              issue_ready,
    output logic              ex_valid,
    output lsu_pkg::mem_op_t  ex_op,
    output lsu_pkg::word_t    ex_result,
    output lsu_pkg::word_t    ex_store_data,
    output lsu_pkg::reg_idx_t ex_wreg,
    output logic              ex_wen,
    output lsu_pkg::word_t    ex_pc
);

    logic           take;
    lsu_pkg::word_t operand_b;
    lsu_pkg::word_t sum;

    // free slot, or the held item leaves on this edge
    assign issue_ready = ~ex_valid | mem_ready;
    assign take        = issue_valid & issue_ready;

    // memory ops add the offset, alu ops add the second source
    assign operand_b = lsu_pkg::is_mem_op(issue_op) ? issue_imm : issue_src2;
    assign sum       = issue_src1 + operand_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (issue_ready) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ex_op         <= issue_op;
            ex_result     <= sum;
            // src2 rides along as the store value
            ex_store_data <= issue_src2;
            ex_wreg       <= issue_wreg;
            ex_wen        <= issue_wen;
            ex_pc         <= issue_pc;
        end
    end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
    parameter int addr_width = lsu_pkg::ram_addr_width_default,
    parameter int latency    = lsu_pkg::ram_latency_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ram_en,
    input  logic                  ram_we,
    input  logic [addr_width-1:0] ram_addr,
    input  lsu_pkg::wmask_t       ram_wmask,
    input  lsu_pkg::word_t        ram_wdata,
    output lsu_pkg::word_t        ram_rdata,
    output logic                  ram_rvalid,
    output logic                  ram_wdone
);

    localparam int depth     = 1 << addr_width;
    localparam int cnt_width = (latency > 1) ? $clog2(latency) : 1;

    lsu_pkg::word_t       mem [0:depth-1];
    logic [cnt_width-1:0] count;
    logic                 pulse;
    logic                 expire;

    assign pulse  = ram_rvalid | ram_wdone;
    // last counted cycle of the access
    assign expire = ram_en & ~pulse & (count == cnt_width'(latency - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            ram_rvalid <= 1'b0;
            ram_wdone  <= 1'b0;
        end else begin
            ram_rvalid <= expire & ~ram_we;
            ram_wdone  <= expire & ram_we;
            // restart after each pulse so a held level starts a new access
            if (!ram_en || pulse || expire) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // commit or fetch on the expiring edge
    always_ff @(posedge clk) begin
        if (expire) begin
            if (ram_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (ram_wmask[i]) begin
                        mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
                    end
                end
            end else begin
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // basic data path types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  wmask_t;

    // operation carried by each item through the slice
    typedef enum logic [3:0] {
        op_alu,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_sb,
        op_sh,
        op_sw
    } mem_op_t;

    // scratchpad defaults for word address width and response delay
    parameter int ram_addr_width_default = 8;
    parameter int ram_latency_default    = 2;

    // anything other than a plain add touches memory
    function automatic logic is_mem_op(mem_op_t op);
        return op != op_alu;
    endfunction

    function automatic logic is_store_op(mem_op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

    function automatic logic is_load_op(mem_op_t op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    endfunction

endpackage

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter int ram_addr_width = lsu_pkg::ram_addr_width_default,
    parameter int ram_latency    = lsu_pkg::ram_latency_default
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  lsu_pkg::mem_op_t  issue_op,
    input  lsu_pkg::word_t    issue_src1,
    input  lsu_pkg::word_t    issue_src2,
    input  lsu_pkg::word_t    issue_imm,
    input  lsu_pkg::reg_idx_t issue_wreg,
    input  logic              issue_wen,
    input  lsu_pkg::word_t    issue_pc,
    output logic              issue_ready,
    output logic              retire_valid,
    output lsu_pkg::mem_op_t  retire_op,
    output lsu_pkg::reg_idx_t retire_wreg,
    output logic              retire_wen,
    output lsu_pkg::word_t    retire_data,
    output lsu_pkg::word_t    retire_pc,
    input  lsu_pkg::reg_idx_t rf_raddr,
    output lsu_pkg::word_t    rf_rdata
);

    // address stage to memory stage
    logic              ex_valid;
    lsu_pkg::mem_op_t  ex_op;
    lsu_pkg::word_t    ex_result;
    lsu_pkg::word_t    ex_store_data;
    lsu_pkg::reg_idx_t ex_wreg;
    logic              ex_wen;
    lsu_pkg::word_t    ex_pc;
    logic              mem_ready;

    // scratchpad port
    logic                      ram_en;
    logic                      ram_we;
    logic [ram_addr_width-1:0] ram_addr;
    lsu_pkg::wmask_t           ram_wmask;
    lsu_pkg::word_t            ram_wdata;
    lsu_pkg::word_t            ram_rdata;
    logic                      ram_rvalid;
    logic                      ram_wdone;

    agu_stage agu0 (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_src1    (issue_src1),
        .issue_src2    (issue_src2),
        .issue_imm     (issue_imm),
        .issue_wreg    (issue_wreg),
        .issue_wen     (issue_wen),
        .issue_pc      (issue_pc),
        .mem_ready     (mem_ready),
        .issue_ready   (issue_ready),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_wreg       (ex_wreg),
        .ex_wen        (ex_wen),
        .ex_pc         (ex_pc)
    );

    // write-back slot goes straight out as the retire port
    mem_stage #(
        .ram_addr_width (ram_addr_width)
    ) mem0 (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_wreg       (ex_wreg),
        .ex_wen        (ex_wen),
        .ex_pc         (ex_pc),
        .ram_rdata     (ram_rdata),
        .ram_rvalid    (ram_rvalid),
        .ram_wdone     (ram_wdone),
        .mem_ready     (mem_ready),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wmask     (ram_wmask),
        .ram_wdata     (ram_wdata),
        .wb_valid      (retire_valid),
        .wb_op         (retire_op),
        .wb_wreg       (retire_wreg),
        .wb_wen        (retire_wen),
        .wb_data       (retire_data),
        .wb_pc         (retire_pc)
    );

    data_ram #(
        .addr_width (ram_addr_width),
        .latency    (ram_latency)
    ) ram0 (
        .clk        (clk),
        .reset      (reset),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wmask  (ram_wmask),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid),
        .ram_wdone  (ram_wdone)
    );

    wb_regfile rf0 (
        .clk      (clk),
        .reset    (reset),
        .wb_valid (retire_valid),
        .wb_wreg  (retire_wreg),
        .wb_wen   (retire_wen),
        .wb_data  (retire_data),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int ram_addr_width = lsu_pkg::ram_addr_width_default
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ex_valid,
    input  lsu_pkg::mem_op_t          ex_op,
    input  lsu_pkg::word_t            ex_result,
    input  lsu_pkg::word_t            ex_store_data,
    input  lsu_pkg::reg_idx_t         ex_wreg,
    input  logic                      ex_wen,
    input  lsu_pkg::word_t            ex_pc,
    input  lsu_pkg::word_t            ram_rdata,
    input  logic                      ram_rvalid,
    input  logic                      ram_wdone,
    output logic                      mem_ready,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [ram_addr_width-1:0] ram_addr,
    output lsu_pkg::wmask_t           ram_wmask,
    output lsu_pkg::word_t            ram_wdata,
    output logic                      wb_valid,
    output lsu_pkg::mem_op_t          wb_op,
    output lsu_pkg::reg_idx_t         wb_wreg,
    output logic                      wb_wen,
    output lsu_pkg::word_t            wb_data,
    output lsu_pkg::word_t            wb_pc
);

    logic           access_done;
    logic           fire;
    logic [1:0]     lane;
    logic [7:0]     load_byte;
    logic [15:0]    load_half;
    lsu_pkg::word_t load_data;
    lsu_pkg::word_t result;

    assign lane = ex_result[1:0];

    // scratchpad request held as a level until the done pulse
    assign ram_en   = ex_valid & lsu_pkg::is_mem_op(ex_op);
    assign ram_we   = lsu_pkg::is_store_op(ex_op);
    assign ram_addr = ex_result[ram_addr_width+1:2];

    assign access_done = ram_rvalid | ram_wdone;
    assign mem_ready   = ~ram_en | access_done;
    assign fire        = ex_valid & mem_ready;

    // store lane steering
    always_comb begin
        case (ex_op)
            lsu_pkg::op_sb: begin
                ram_wdata = {24'h0, ex_store_data[7:0]} << {lane, 3'b000};
                ram_wmask = 4'b0001 << lane;
            end
            lsu_pkg::op_sh: begin
                // half lane picked by bit 1 only
                if (lane[1]) begin
                    ram_wdata = {ex_store_data[15:0], 16'h0};
                    ram_wmask = 4'b1100;
                end else begin
                    ram_wdata = {16'h0, ex_store_data[15:0]};
                    ram_wmask = 4'b0011;
                end
            end
            default: begin
                ram_wdata = ex_store_data;
                ram_wmask = 4'b1111;
            end
        endcase
    end

    // load lane select and extension
    assign load_byte = ram_rdata[{lane, 3'b000} +: 8];
    assign load_half = lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (ex_op)
            lsu_pkg::op_lb:  load_data = {{24{load_byte[7]}}, load_byte};
            lsu_pkg::op_lbu: load_data = {24'h0, load_byte};
            lsu_pkg::op_lh:  load_data = {{16{load_half[15]}}, load_half};
            lsu_pkg::op_lhu: load_data = {16'h0, load_half};
            default:         load_data = ram_rdata;
        endcase
    end

    // stores and alu ops both retire the sum
    assign result = lsu_pkg::is_load_op(ex_op) ? load_data : ex_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= fire;
        end
    end

    // write-back slot pulses once per item
    always_ff @(posedge clk) begin
        if (fire) begin
            wb_op   <= ex_op;
            wb_wreg <= ex_wreg;
            wb_wen  <= ex_wen;
            wb_data <= result;
            wb_pc   <= ex_pc;
        end
    end

endmodule

/* hdl/wb_regfile.sv */
`timescale 1ns/1ps

module wb_regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_valid,
    input  lsu_pkg::reg_idx_t wb_wreg,
    input  logic              wb_wen,
    input  lsu_pkg::word_t    wb_data,
    input  lsu_pkg::reg_idx_t rf_raddr,
    output lsu_pkg::word_t    rf_rdata
);

    lsu_pkg::word_t regs [0:31];
    logic           write;

    // register 0 stays hard zero
    assign write = wb_valid & wb_wen & (wb_wreg != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write) begin
            regs[wb_wreg] <= wb_data;
        end
    end

    // asynchronous read
    assign rf_rdata = regs[rf_raddr];

endmodule

/* sources.f */
hdl/lsu_pkg.sv
hdl/agu_stage.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/wb_regfile.sv
hdl/lsu_top.sv
bench/lsu_tb.sv
